/* csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`default_nettype none

// machine csr addresses
`define CSR_MSTATUS    12'h300
`define CSR_MTVEC      12'h305
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342

// mstatus at reset, uxl/sxl fixed, mpp = m
`define MSTATUS_RESET  64'h0000_000a_0000_1800

// writable mstatus bits: mie, mpie, mpp
`define MSTATUS_WMASK  64'h0000_0000_0000_1888
`define MSTATUS_MIE    3
`define MSTATUS_MPIE   7
`define MSTATUS_MPP_LO 11

// direct mode only, low two bits tied to zero
`define MTVEC_WMASK    64'hffff_ffff_ffff_fffc

// command queue entries, power of two
`define CSR_FIFO_DEPTH 4

`default_nettype wire

`endif

/* csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // opcode field of the wishbone address, bits 14:12
    // rw/rs/rc follow the funct3 coding of the csr instructions
    typedef enum logic [2:0] {
        CSR_RW   = 3'b001,
        CSR_RS   = 3'b010,
        CSR_RC   = 3'b011,
        CSR_TRAP = 3'b100,
        CSR_MRET = 3'b101
    } csr_op_e;

    // one posted command, 79 bits
    // for a trap, addr carries the cause and data the faulting pc
    typedef struct packed {
        csr_op_e     op;
        logic [11:0] addr;
        logic [63:0] data;
    } csr_cmd_t;

    // multi-register update for trap entry and mret
    typedef struct packed {
        logic        en;
        logic [63:0] mstatus;
        logic [63:0] mepc;
        logic [63:0] mcause;
        logic        mepc_en;
        logic        mcause_en;
    } csr_trap_upd_t;

endpackage

`default_nettype wire

/* csr_wb_front.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_wb_front (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    input  wire logic              wb_we_i,
    input  wire logic [14:0]       wb_adr_i,
    input  wire logic [63:0]       wb_dat_i,
    output logic      [63:0]       wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   push_o,
    output csr_pkg::csr_cmd_t      cmd_o,
    input  wire logic              full_i,
    input  wire logic              empty_i,
    input  wire logic              busy_i,
    output logic      [11:0]       rd_addr_o,
    input  wire logic [63:0]       rd_data_i
);
    import csr_pkg::*;

    typedef enum logic {IDLE, ACK} state_e;

    state_e  state;
    csr_op_e op;
    logic    op_ok;
    logic    req;
    logic    wr_go;
    logic    rd_go;

    // new request only in idle, so one bus cycle is taken once
    assign req   = wb_cyc_i && wb_stb_i && (state == IDLE);
    // full queue holds off the ack
    assign wr_go = req && wb_we_i && !full_i;
    // reads wait for queue and executor to drain
    assign rd_go = req && !wb_we_i && empty_i && !busy_i;

    // opcode decode
    always_comb begin
        op    = CSR_RW;
        op_ok = 1'b1;
        case (wb_adr_i[14:12])
            3'b001:  op = CSR_RW;
            3'b010:  op = CSR_RS;
            3'b011:  op = CSR_RC;
            3'b100:  op = CSR_TRAP;
            3'b101:  op = CSR_MRET;
            // undefined opcode is acked and dropped
            default: op_ok = 1'b0;
        endcase
    end

    assign push_o     = wr_go && op_ok;
    assign cmd_o.op   = op;
    assign cmd_o.addr = wb_adr_i[11:0];
    assign cmd_o.data = wb_dat_i;
    assign rd_addr_o  = wb_adr_i[11:0];
    assign wb_ack_o   = (state == ACK);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (wr_go || rd_go) state <= ACK;
                // master drops stb after the ack
                ACK:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // read data sampled with the accept
    always_ff @(posedge clk) begin
        if (rd_go) begin
            wb_dat_o <= rd_data_i;
        end
    end

    // master holds stb until it sees the ack
    a_stb_held: assert property (@(posedge clk) disable iff (!rst)
        (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> (wb_cyc_i && wb_stb_i));

endmodule

`default_nettype wire

/* csr_cmd_fifo.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"
`default_nettype none

module csr_cmd_fifo (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              push_i,
    input  wire csr_pkg::csr_cmd_t cmd_i,
    input  wire logic              pop_i,
    output csr_pkg::csr_cmd_t      head_o,
    output logic                   full_o,
    output logic                   empty_o
);
    import csr_pkg::*;

    localparam int AW = $clog2(`CSR_FIFO_DEPTH);
    localparam logic [AW:0] DEPTH = `CSR_FIFO_DEPTH;

    csr_cmd_t      mem [`CSR_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    // push into a full queue only alongside a pop
    assign do_push = push_i && (!full_o || pop_i);
    assign do_pop  = pop_i && !empty_o;
    assign full_o  = (count == DEPTH);
    assign empty_o = (count == '0);
    assign head_o  = mem[rd_ptr];

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= cmd_i;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst) pop_i |-> !empty_o);
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
        (push_i && full_o) |-> pop_i);

endmodule

`default_nettype wire

/* csr_exec.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"
`default_nettype none

module csr_exec (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              empty_i,
    input  wire csr_pkg::csr_cmd_t head_i,
    output logic                   pop_o,
    output logic                   busy_o,
    output logic      [11:0]       rd_addr_o,
    input  wire logic [63:0]       rd_data_i,
    input  wire logic [63:0]       mstatus_i,
    output logic                   wr_en_o,
    output logic      [11:0]       wr_addr_o,
    output logic      [63:0]       wr_data_o,
    output csr_pkg::csr_trap_upd_t trap_o
);
    import csr_pkg::*;

    csr_cmd_t cur;
    logic     busy;

    // pop then apply takes two cycles per command
    assign pop_o  = !busy && !empty_i;
    assign busy_o = busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
        end else begin
            busy <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            cur <= head_i;
        end
    end

    // old value of the target csr
    assign rd_addr_o = cur.addr;
    assign wr_addr_o = cur.addr;

    always_comb begin
        wr_en_o          = 1'b0;
        wr_data_o        = rd_data_i;
        trap_o.en        = 1'b0;
        trap_o.mstatus   = mstatus_i;
        // pc and zero-extended cause
        trap_o.mepc      = cur.data;
        trap_o.mcause    = {52'b0, cur.addr};
        trap_o.mepc_en   = 1'b0;
        trap_o.mcause_en = 1'b0;
        case (cur.op)
            CSR_RW: begin
                wr_en_o   = busy;
                wr_data_o = cur.data;
            end
            CSR_RS: begin
                wr_en_o   = busy;
                wr_data_o = rd_data_i | cur.data;
            end
            CSR_RC: begin
                wr_en_o   = busy;
                wr_data_o = rd_data_i & ~cur.data;
            end
            CSR_TRAP: begin
                trap_o.en        = busy;
                trap_o.mepc_en   = busy;
                trap_o.mcause_en = busy;
                // mie saved to mpie, interrupts off, mpp = m
                trap_o.mstatus[`MSTATUS_MPIE] = mstatus_i[`MSTATUS_MIE];
                trap_o.mstatus[`MSTATUS_MIE]  = 1'b0;
                trap_o.mstatus[`MSTATUS_MPP_LO +: 2] = 2'b11;
            end
            CSR_MRET: begin
                trap_o.en = busy;
                trap_o.mstatus[`MSTATUS_MIE]  = mstatus_i[`MSTATUS_MPIE];
                trap_o.mstatus[`MSTATUS_MPIE] = 1'b1;
            end
            default: ;
        endcase
    end

    // every latched command reaches the registers
    a_cmd_applied: assert property (@(posedge clk) disable iff (!rst)
        busy |-> (wr_en_o || trap_o.en));

endmodule

`default_nettype wire

/* csr_regs.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"
`default_nettype none

module csr_regs (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [11:0]            rd_a_addr_i,
    output logic      [63:0]            rd_a_data_o,
    input  wire logic [11:0]            rd_b_addr_i,
    output logic      [63:0]            rd_b_data_o,
    input  wire logic                   wr_en_i,
    input  wire logic [11:0]            wr_addr_i,
    input  wire logic [63:0]            wr_data_i,
    input  wire csr_pkg::csr_trap_upd_t trap_i,
    output logic      [63:0]            mtvec_o,
    output logic      [63:0]            mstatus_o
);
    logic [63:0] mstatus;
    logic [63:0] mtvec;
    logic [63:0] mepc;
    logic [63:0] mcause;

    // read-only mstatus fields stay at their reset value
    function automatic logic [63:0] mstatus_warl(input logic [63:0] v);
        return (v & `MSTATUS_WMASK) | (`MSTATUS_RESET & ~`MSTATUS_WMASK);
    endfunction

    // shared read decode where an unknown address reads zero
    function automatic logic [63:0] rd_mux(input logic [11:0] addr);
        logic [63:0] val;
        case (addr)
            `CSR_MSTATUS: val = mstatus;
            `CSR_MTVEC:   val = mtvec;
            `CSR_MEPC:    val = mepc;
            `CSR_MCAUSE:  val = mcause;
            default:      val = 64'b0;
        endcase
        return val;
    endfunction

    // port a for the executor, port b for the bus
    always_comb begin
        rd_a_data_o = rd_mux(rd_a_addr_i);
        rd_b_data_o = rd_mux(rd_b_addr_i);
    end

    // straight to the core trap logic
    assign mtvec_o   = mtvec;
    assign mstatus_o = mstatus;

    always_ff @(posedge clk) begin
        if (!rst) begin
            mstatus <= `MSTATUS_RESET;
            mtvec   <= 64'b0;
            mepc    <= 64'b0;
            mcause  <= 64'b0;
        end else if (trap_i.en) begin
            // trap entry or mret updates several csrs in one edge
            mstatus <= mstatus_warl(trap_i.mstatus);
            if (trap_i.mepc_en)   mepc   <= trap_i.mepc;
            if (trap_i.mcause_en) mcause <= trap_i.mcause;
        end else if (wr_en_i) begin
            case (wr_addr_i)
                `CSR_MSTATUS: mstatus <= mstatus_warl(wr_data_i);
                `CSR_MTVEC:   mtvec   <= wr_data_i & `MTVEC_WMASK;
                `CSR_MEPC:    mepc    <= wr_data_i;
                `CSR_MCAUSE:  mcause  <= wr_data_i;
                // writes elsewhere are dropped
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* csr_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_subsys_top (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [14:0] wb_adr_i,
    input  wire logic [63:0] wb_dat_i,
    output logic      [63:0] wb_dat_o,
    output logic             wb_ack_o,
    output logic      [63:0] mtvec_o,
    output logic      [63:0] mstatus_o
);
    import csr_pkg::*;

    // front end to queue
    logic          push;
    csr_cmd_t      cmd;
    logic          full;
    // queue to executor
    logic          empty;
    logic          pop;
    csr_cmd_t      head;
    logic          busy;
    // register file ports
    logic [11:0]   rd_a_addr;
    logic [63:0]   rd_a_data;
    logic [11:0]   rd_b_addr;
    logic [63:0]   rd_b_data;
    logic          wr_en;
    logic [11:0]   wr_addr;
    logic [63:0]   wr_data;
    csr_trap_upd_t trap;

    csr_wb_front u_front (
        .clk(clk), .rst(rst), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .push_o(push), .cmd_o(cmd), .full_i(full), .empty_i(empty), .busy_i(busy),
        .rd_addr_o(rd_b_addr), .rd_data_i(rd_b_data)
    );

    csr_cmd_fifo u_fifo (
        .clk(clk), .rst(rst), .push_i(push), .cmd_i(cmd), .pop_i(pop),
        .head_o(head), .full_o(full), .empty_o(empty)
    );

    csr_exec u_exec (
        .clk(clk), .rst(rst), .empty_i(empty), .head_i(head), .pop_o(pop), .busy_o(busy),
        .rd_addr_o(rd_a_addr), .rd_data_i(rd_a_data), .mstatus_i(mstatus_o),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .trap_o(trap)
    );

    csr_regs u_regs (
        .clk(clk), .rst(rst), .rd_a_addr_i(rd_a_addr), .rd_a_data_o(rd_a_data),
        .rd_b_addr_i(rd_b_addr), .rd_b_data_o(rd_b_data), .wr_en_i(wr_en),
        .wr_addr_i(wr_addr), .wr_data_i(wr_data), .trap_i(trap),
        .mtvec_o(mtvec_o), .mstatus_o(mstatus_o)
    );

endmodule

`default_nettype wire

/* csr_subsys_tb.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"
`default_nettype none

module csr_subsys_tb;
    import csr_pkg::*;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [14:0] wb_adr;
    logic [63:0] wb_dat_w;
    logic [63:0] wb_dat_r;
    logic        wb_ack;
    logic [63:0] mtvec;
    logic [63:0] mstatus;

    // shadow csrs in order mstatus, mtvec, mepc, mcause
    logic [63:0] shadow [4];
    // pending comparisons
    logic [63:0] exp_q [$];
    logic [63:0] act_q [$];
    string       what_q [$];
    event        check_ev;
    string       test_name;
    int          bus_cycles;
    int          cycle_count;
    int          test_errors;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    csr_subsys_top uut (
        .clk(clk), .rst(rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
        .mtvec_o(mtvec), .mstatus_o(mstatus)
    );

    always #20 clk = ~clk;

    // watchdog limit grows with the bus cycles issued so far
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 20 * bus_cycles + 100) begin
            $display("timeout: bus cycle not acknowledged after %0d clock cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // {hit, slot} for an address
    function automatic logic [2:0] csr_slot(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS: return 3'b100;
            `CSR_MTVEC:   return 3'b101;
            `CSR_MEPC:    return 3'b110;
            `CSR_MCAUSE:  return 3'b111;
            default:      return 3'b000;
        endcase
    endfunction

    // applies one command to the shadow csrs
    // returns what a read of addr gives before the command
    function automatic logic [63:0] csr_model(input logic is_read, input csr_op_e op,
                                             input logic [11:0] addr, input logic [63:0] data);
        logic [2:0]  slot;
        logic [63:0] old;
        logic [63:0] nv;
        logic [63:0] ms;
        slot = csr_slot(addr);
        old  = slot[2] ? shadow[slot[1:0]] : 64'b0;
        ms   = shadow[0];
        if (is_read) return old;
        case (op)
            CSR_RW: nv = data;
            CSR_RS: nv = old | data;
            CSR_RC: nv = old & ~data;
            CSR_TRAP: begin
                // pc into mepc, cause zero-extended
                shadow[2] = data;
                shadow[3] = {52'b0, addr};
                // mpie <= mie, mie off, mpp = 3
                ms[7]     = ms[3];
                ms[3]     = 1'b0;
                ms[12:11] = 2'b11;
                shadow[0] = ms;
                return old;
            end
            CSR_MRET: begin
                ms[3]     = ms[7];
                ms[7]     = 1'b1;
                shadow[0] = ms;
                return old;
            end
            default: return old;
        endcase
        if (slot == 3'b100) begin
            // only mie, mpie and mpp take the new value
            ms        = `MSTATUS_RESET;
            ms[3]     = nv[3];
            ms[7]     = nv[7];
            ms[12:11] = nv[12:11];
            shadow[0] = ms;
        end else if (slot == 3'b101) begin
            // direct mode only
            shadow[1] = {nv[63:2], 2'b00};
        end else if (slot[2]) begin
            shadow[slot[1:0]] = nv;
        end
        return old;
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [11:0] rand12();
        logic [31:0] r;
        r = $urandom();
        return r[11:0];
    endfunction

    // one of the four csrs, or a random address that is almost always unmapped
    function automatic logic [11:0] pick_addr();
        case ($urandom_range(0, 4))
            0:       return `CSR_MSTATUS;
            1:       return `CSR_MTVEC;
            2:       return `CSR_MEPC;
            3:       return `CSR_MCAUSE;
            default: return rand12();
        endcase
    endfunction

    // picks among the first n of rw, rs, rc, trap and mret
    function automatic csr_op_e pick_op(input int n);
        case ($urandom_range(0, n - 1))
            0:       return CSR_RW;
            1:       return CSR_RS;
            2:       return CSR_RC;
            3:       return CSR_TRAP;
            default: return CSR_MRET;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        what_q.push_back(what);
        exp_q.push_back(exp);
        act_q.push_back(act);
        -> check_ev;
    endtask

    // compare process
    always begin : compare_results
        logic [63:0] exp;
        logic [63:0] act;
        string       what;
        @(check_ev);
        while (exp_q.size() > 0) begin
            exp  = exp_q.pop_front();
            act  = act_q.pop_front();
            what = what_q.pop_front();
            assert (act === exp) else begin
                $display("MISMATCH %s (%s): expected %h actual %h", test_name, what, exp, act);
                test_errors++;
                errors++;
            end
        end
    end

    // posted command with the model updated as it is issued
    task automatic wb_write(input csr_op_e op, input logic [11:0] addr, input logic [63:0] data);
        bus_cycles++;
        void'(csr_model(1'b0, op, addr, data));
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = {op, addr};
        wb_dat_w = data;
        // registered ack is looked at mid-cycle
        do begin
            @(negedge clk);
        end while (!wb_ack);
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [11:0] addr, input string what);
        logic [63:0] exp;
        bus_cycles++;
        exp      = csr_model(1'b1, CSR_RW, addr, 64'b0);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b0;
        wb_adr   = {3'b000, addr};
        wb_dat_w = 64'b0;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        check_value(what, exp, wb_dat_r);
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // direct outputs against the shadow
    task automatic check_outputs();
        @(negedge clk);
        check_value("mtvec_o", shadow[1], mtvec);
        check_value("mstatus_o", shadow[0], mstatus);
    endtask

    task automatic finish_test();
        @(posedge clk);
        #2;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic read_all(input string tag);
        wb_read(`CSR_MSTATUS, {tag, " mstatus"});
        wb_read(`CSR_MTVEC, {tag, " mtvec"});
        wb_read(`CSR_MEPC, {tag, " mepc"});
        wb_read(`CSR_MCAUSE, {tag, " mcause"});
    endtask

    initial begin
        int          i;
        logic [11:0] a;
        csr_op_e     op;
        clk       = 1'b0;
        rst       = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        shadow[0] = `MSTATUS_RESET;
        shadow[1] = 64'b0;
        shadow[2] = 64'b0;
        shadow[3] = 64'b0;
        void'($urandom(32'h40ab));
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b1;

        test_name = "reset_values";
        read_all("reset");
        wb_read(12'h7c0, "unmapped 7c0");
        check_outputs();
        finish_test();

        test_name = "write_masks";
        for (i = 0; i < 40; i++) begin
            a  = pick_addr();
            op = pick_op(3);
            wb_write(op, a, rand64());
            wb_read(a, $sformatf("%s %h", op.name(), a));
        end
        check_outputs();
        finish_test();

        test_name = "trap_entry";
        // mie set with mpie and mpp cleared so every trap change shows
        wb_write(CSR_RW, `CSR_MSTATUS, 64'h8);
        wb_write(CSR_TRAP, rand12(), rand64());
        read_all("trap");
        check_outputs();
        finish_test();

        test_name = "trap_return";
        wb_write(CSR_MRET, 12'h000, 64'b0);
        wb_read(`CSR_MSTATUS, "mstatus after mret");
        wb_read(`CSR_MEPC, "mepc kept");
        // second round goes in with mie and mpie low
        wb_write(CSR_RC, `CSR_MSTATUS, 64'h88);
        wb_write(CSR_TRAP, 12'h00b, rand64());
        wb_write(CSR_MRET, 12'h000, 64'b0);
        read_all("second mret");
        finish_test();

        test_name = "burst_ordering";
        // more writes than queue entries and a read straight after
        for (i = 0; i < `CSR_FIFO_DEPTH + 4; i++) begin
            wb_write(pick_op(3), i[0] ? `CSR_MEPC : `CSR_MTVEC, rand64());
        end
        wb_read(`CSR_MEPC, "mepc after burst");
        wb_read(`CSR_MTVEC, "mtvec after burst");
        finish_test();

        test_name = "random_mix";
        for (i = 0; i < 200; i++) begin
            op = pick_op(5);
            wb_write(op, pick_addr(), rand64());
            a = pick_addr();
            wb_read(a, $sformatf("step %0d %s, read %h", i, op.name(), a));
        end
        read_all("final");
        check_outputs();
        finish_test();

        $display("tests passed %0d, failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* csr_subsys_top.f */
+incdir+.
csr_pkg.sv
csr_wb_front.sv
csr_cmd_fifo.sv
csr_exec.sv
csr_regs.sv
csr_subsys_top.sv
csr_subsys_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = csr_subsys_tb
FILELIST  = csr_subsys_top.f
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
